// File: files.f
ic_pkg.sv
ic_sram.sv
ic_req_ctrl.sv
ic_way.sv
ic_way_sel.sv
ic_mem.sv
tb_ic_mem.sv

// File: ic_mem.sv
`timescale 1ns/1ps
`default_nettype none

module ic_mem #(
   parameter int ICACHE_TAG_HIGH = ic_pkg::IC_TAG_HIGH_DEF
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  ic_pkg::ic_addr_t            ic_rw_addr,
   input  logic                        ic_rd_en,
   input  ic_pkg::ic_way_vec_t         ic_wr_en,
   input  ic_pkg::ic_data_t            ic_wr_data,
   input  ic_pkg::ic_way_vec_t         ic_tag_valid,       // Response cycle
   input  ic_pkg::ic_dbg_addr_t        ic_debug_addr,
   input  logic                        ic_debug_rd_en,
   input  logic                        ic_debug_wr_en,
   input  ic_pkg::ic_way_vec_t         ic_debug_way,
   input  logic [32-ICACHE_TAG_HIGH:0] ic_debug_wr_data,
   output ic_pkg::ic_way_vec_t         ic_rd_hit,
   output ic_pkg::ic_data_t            ic_rd_data,
   output logic                        ic_tag_perr,
   output logic [32-ICACHE_TAG_HIGH:0] ictag_debug_rd_data
);
   import ic_pkg::*;

   logic [ICACHE_TAG_HIGH-7:0]                 tag_index;
   logic [ICACHE_TAG_HIGH-4:0]                 data_index;
   logic [32-ICACHE_TAG_HIGH:0]                tag_wr_word;
   ic_data_t                                   data_wr_word;
   ic_way_vec_t                                tag_wren;
   ic_way_vec_t                                data_wren;
   logic [31:ICACHE_TAG_HIGH]                  rd_tag_q;
   ic_way_vec_t                                debug_rd_way_q;
   ic_way_vec_t                                way_hit;
   ic_way_vec_t                                way_perr;
   ic_data_t [NUM_WAYS-1:0]                    way_data;
   logic [NUM_WAYS-1:0][32-ICACHE_TAG_HIGH:0]  way_tag_raw;

   ic_req_ctrl #(
      .ICACHE_TAG_HIGH (ICACHE_TAG_HIGH)
   ) req_ctrl_inst (
      .clk              (clk),
      .arst_n           (arst_n),
      .ic_rw_addr       (ic_rw_addr),
      .ic_rd_en         (ic_rd_en),
      .ic_wr_en         (ic_wr_en),
      .ic_wr_data       (ic_wr_data),
      .ic_debug_addr    (ic_debug_addr),
      .ic_debug_rd_en   (ic_debug_rd_en),
      .ic_debug_wr_en   (ic_debug_wr_en),
      .ic_debug_way     (ic_debug_way),
      .ic_debug_wr_data (ic_debug_wr_data),
      .tag_index        (tag_index),
      .data_index       (data_index),
      .tag_wr_word      (tag_wr_word),
      .data_wr_word     (data_wr_word),
      .tag_wren         (tag_wren),
      .data_wren        (data_wren),
      .rd_tag_q         (rd_tag_q),
      .debug_rd_way_q   (debug_rd_way_q)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Ways share index and write words, each with its own enables
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < NUM_WAYS; i++) begin : WAYS
      ic_way #(
         .ICACHE_TAG_HIGH (ICACHE_TAG_HIGH)
      ) way_inst (
         .clk          (clk),
         .tag_index    (tag_index),
         .data_index   (data_index),
         .tag_wr_word  (tag_wr_word),
         .data_wr_word (data_wr_word),
         .tag_we       (tag_wren[i]),
         .data_we      (data_wren[i]),
         .rd_tag_q     (rd_tag_q),
         .tag_valid    (ic_tag_valid[i]),
         .hit          (way_hit[i]),
         .tag_perr     (way_perr[i]),
         .tag_raw      (way_tag_raw[i]),
         .data_out     (way_data[i])
      );
   end

   ic_way_sel #(
      .ICACHE_TAG_HIGH (ICACHE_TAG_HIGH)
   ) way_sel_inst (
      .way_hit             (way_hit),
      .way_perr            (way_perr),
      .way_data            (way_data),
      .way_tag_raw         (way_tag_raw),
      .debug_rd_way_q      (debug_rd_way_q),
      .ic_rd_hit           (ic_rd_hit),
      .ic_rd_data          (ic_rd_data),
      .ic_tag_perr         (ic_tag_perr),
      .ictag_debug_rd_data (ictag_debug_rd_data)
   );

endmodule

`default_nettype wire

// File: ic_pkg.sv
`default_nettype none

package ic_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Cache geometry
   ////////////////////////////////////////////////////////////////////////////

   localparam int NUM_WAYS        = 4;    // Ways per set
   localparam int IC_TAG_HIGH_DEF = 12;   // 64 tag entries, 512 data entries per way

   // Each fetch word carries two instructions with two parity bits apiece
   localparam int IC_INSTR_W  = 32;
   localparam int IC_INSTR_PW = 2;
   localparam int IC_DATA_W   = 2 * (IC_INSTR_W + IC_INSTR_PW);

   ////////////////////////////////////////////////////////////////////////////
   // Shared types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [NUM_WAYS-1:0]  ic_way_vec_t;   // One bit per way
   typedef logic [IC_DATA_W-1:0] ic_data_t;      // 68-bit fetch word
   typedef logic [31:2]          ic_addr_t;      // Fetch and fill address
   typedef logic [15:2]          ic_dbg_addr_t;  // Debug tag address

endpackage

`default_nettype wire

// File: ic_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ic_req_ctrl #(
   parameter int ICACHE_TAG_HIGH = ic_pkg::IC_TAG_HIGH_DEF
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  ic_pkg::ic_addr_t            ic_rw_addr,
   input  logic                        ic_rd_en,
   input  ic_pkg::ic_way_vec_t         ic_wr_en,          // One-hot fill way
   input  ic_pkg::ic_data_t            ic_wr_data,
   input  ic_pkg::ic_dbg_addr_t        ic_debug_addr,
   input  logic                        ic_debug_rd_en,
   input  logic                        ic_debug_wr_en,
   input  ic_pkg::ic_way_vec_t         ic_debug_way,
   input  logic [32-ICACHE_TAG_HIGH:0] ic_debug_wr_data,  // Parity in top bit
   output logic [ICACHE_TAG_HIGH-7:0]  tag_index,
   output logic [ICACHE_TAG_HIGH-4:0]  data_index,
   output logic [32-ICACHE_TAG_HIGH:0] tag_wr_word,
   output ic_pkg::ic_data_t            data_wr_word,
   output ic_pkg::ic_way_vec_t         tag_wren,
   output ic_pkg::ic_way_vec_t         data_wren,
   output logic [31:ICACHE_TAG_HIGH]   rd_tag_q,          // Compare tag, next cycle
   output ic_pkg::ic_way_vec_t         debug_rd_way_q
);
   import ic_pkg::*;

   typedef logic [32-ICACHE_TAG_HIGH:0] tag_word_t;

   logic        last_chunk;
   logic        new_tag_par;
   logic        debug_access;
   tag_word_t   fill_tag_word;
   ic_way_vec_t fill_tag_wren;
   ic_way_vec_t debug_wr_ways;
   ic_way_vec_t debug_rd_ways;

   ////////////////////////////////////////////////////////////////////////////
   // Write path
   ////////////////////////////////////////////////////////////////////////////

   assign last_chunk    = (ic_rw_addr[5:3] == 3'b111);          // Eighth 8-byte chunk
   assign new_tag_par   = ^ic_rw_addr[31:ICACHE_TAG_HIGH];      // Even parity
   assign fill_tag_word = {new_tag_par, ic_rw_addr[31:ICACHE_TAG_HIGH]};

   assign fill_tag_wren = ic_wr_en & {NUM_WAYS{last_chunk}};
   assign debug_wr_ways = ic_debug_way & {NUM_WAYS{ic_debug_wr_en}};
   assign debug_rd_ways = ic_debug_way & {NUM_WAYS{ic_debug_rd_en}};

   // Debug data goes in as given, so a bad parity bit can be planted
   assign tag_wr_word  = ic_debug_wr_en ? ic_debug_wr_data : fill_tag_word;
   assign tag_wren     = fill_tag_wren | debug_wr_ways;

   assign data_wr_word = ic_wr_data;
   assign data_wren    = ic_wr_en;                               // Every chunk

   ////////////////////////////////////////////////////////////////////////////
   // Indexes
   ////////////////////////////////////////////////////////////////////////////

   assign debug_access = ic_debug_rd_en | ic_debug_wr_en;

   assign tag_index  = debug_access ? ic_debug_addr[ICACHE_TAG_HIGH-1:6]
                                    : ic_rw_addr[ICACHE_TAG_HIGH-1:6];
   assign data_index = ic_rw_addr[ICACHE_TAG_HIGH-1:3];

   ////////////////////////////////////////////////////////////////////////////
   // Response-cycle state
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_tag_q       <= '0;
         debug_rd_way_q <= '0;
      end else begin
         if (ic_rd_en) begin
            rd_tag_q <= ic_rw_addr[31:ICACHE_TAG_HIGH];        // Held between fetches
         end
         debug_rd_way_q <= debug_rd_ways;                      // Single-cycle pulse
      end
   end

endmodule

`default_nettype wire

// File: ic_sram.sv
`timescale 1ns/1ps
`default_nettype none

module ic_sram #(
   parameter int  DEPTH  = 64,
   parameter type word_t = logic
) (
   input  logic                     clk,
   input  logic                     we,    // Write strobe
   input  logic [$clog2(DEPTH)-1:0] addr,
   input  word_t                    d,
   output word_t                    q      // Valid one edge after addr
);

   word_t mem [DEPTH];

   // Read is taken every cycle, so q always tracks the last sampled address.
   // A write and a read of the same entry return the old contents.
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= d;
      end
      q <= mem[addr];
   end

endmodule

`default_nettype wire

// File: ic_testdata.txt
// op addr way wdata tag_valid exp_a exp_b, op 1 fill, 2 fetch (exp_a hit, exp_b perr)
// op 3 debug write (wdata is the tag word), 4 debug read (exp_a tag), 0 ends the list
// Line A into way 2, all eight chunks, then fetches that hit
1 00123440 4 0 0 0 0
1 00123448 4 0 0 0 0
1 00123450 4 0 0 0 0
1 00123458 4 0 0 0 0
1 00123460 4 0 0 0 0
1 00123468 4 0 0 0 0
1 00123470 4 0 0 0 0
1 00123478 4 0 0 0 0
2 00123440 0 0 4 4 0
2 00123458 0 0 4 4 0
2 00123478 0 0 4 4 0
// Line B into way 3, first and last chunk
1 abcde780 8 0 0 0 0
1 abcde7b8 8 0 0 0 0
// Known tag in way 1, then a fill without the last chunk leaves it
3 00000100 2 0 0 0 0
1 00005120 2 0 0 0 0
1 00005128 2 0 0 0 0
1 00005130 2 0 0 0 0
2 00005128 0 0 2 0 0
// Line A again with way 2 not valid
2 00123440 0 0 0 0 0
// Debug tag reads of way 2 and way 3
4 00000440 4 0 0 123 0
4 00000780 8 0 0 1abcde 0
// Bad parity planted in way 0 at line A's index
3 00000440 1 000001 0 0 0
2 00123448 0 0 1 0 1
2 00123448 0 0 5 4 1
2 00123448 0 0 4 4 0
// Back to back fetches across ways 2 and 3
2 00123460 0 0 4 4 0
2 abcde7b8 0 0 8 8 0
2 00123468 0 0 4 4 0
2 abcde780 0 0 8 8 0
0 00000000 0 0 0 0 0

// File: ic_way.sv
`timescale 1ns/1ps
`default_nettype none

module ic_way #(
   parameter int ICACHE_TAG_HIGH = ic_pkg::IC_TAG_HIGH_DEF
) (
   input  logic                        clk,
   input  logic [ICACHE_TAG_HIGH-7:0]  tag_index,
   input  logic [ICACHE_TAG_HIGH-4:0]  data_index,
   input  logic [32-ICACHE_TAG_HIGH:0] tag_wr_word,
   input  ic_pkg::ic_data_t            data_wr_word,
   input  logic                        tag_we,
   input  logic                        data_we,
   input  logic [31:ICACHE_TAG_HIGH]   rd_tag_q,
   input  logic                        tag_valid,     // From caller, response cycle
   output logic                        hit,
   output logic                        tag_perr,
   output logic [32-ICACHE_TAG_HIGH:0] tag_raw,       // Stored word with parity
   output ic_pkg::ic_data_t            data_out
);
   import ic_pkg::*;

   localparam int TAG_BITS   = 32 - ICACHE_TAG_HIGH;     // Address tag, no parity
   localparam int TAG_DEPTH  = 2 ** (ICACHE_TAG_HIGH - 6);
   localparam int DATA_DEPTH = 2 ** (ICACHE_TAG_HIGH - 3);

   typedef logic [TAG_BITS:0] tag_word_t;

   ic_sram #(
      .DEPTH  (TAG_DEPTH),
      .word_t (tag_word_t)
   ) tag_ram (
      .clk  (clk),
      .we   (tag_we),
      .addr (tag_index),
      .d    (tag_wr_word),
      .q    (tag_raw)
   );

   ic_sram #(
      .DEPTH  (DATA_DEPTH),
      .word_t (ic_data_t)
   ) data_ram (
      .clk  (clk),
      .we   (data_we),
      .addr (data_index),
      .d    (data_wr_word),
      .q    (data_out)
   );

   // Compare and parity check on the word read at the previous edge
   assign hit      = tag_valid & (tag_raw[TAG_BITS-1:0] == rd_tag_q);
   assign tag_perr = tag_valid & (^tag_raw);                    // Odd count is an error

endmodule

`default_nettype wire

// File: ic_way_sel.sv
`timescale 1ns/1ps
`default_nettype none

module ic_way_sel #(
   parameter int ICACHE_TAG_HIGH = ic_pkg::IC_TAG_HIGH_DEF
) (
   input  ic_pkg::ic_way_vec_t                               way_hit,
   input  ic_pkg::ic_way_vec_t                               way_perr,
   input  ic_pkg::ic_data_t [ic_pkg::NUM_WAYS-1:0]           way_data,
   input  logic [ic_pkg::NUM_WAYS-1:0][32-ICACHE_TAG_HIGH:0] way_tag_raw,
   input  ic_pkg::ic_way_vec_t                               debug_rd_way_q,
   output ic_pkg::ic_way_vec_t                               ic_rd_hit,
   output ic_pkg::ic_data_t                                  ic_rd_data,
   output logic                                              ic_tag_perr,
   output logic [32-ICACHE_TAG_HIGH:0]                       ictag_debug_rd_data
);
   import ic_pkg::*;

   assign ic_rd_hit   = way_hit;
   assign ic_tag_perr = |way_perr;                              // Already valid-qualified

   // AND-OR way mux. A clean cache has at most one hitting way; a miss reads zero
   always_comb begin
      ic_rd_data = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (way_hit[w]) begin
            ic_rd_data = ic_rd_data | way_data[w];
         end
      end
   end

   always_comb begin
      ictag_debug_rd_data = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (debug_rd_way_q[w]) begin
            ictag_debug_rd_data = ictag_debug_rd_data | way_tag_raw[w];  // Raw, parity kept
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_ic_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ic_mem;
   import ic_pkg::*;

   localparam int TAG_HIGH   = IC_TAG_HIGH_DEF;
   localparam int DATA_DEPTH = 2 ** (TAG_HIGH - 3);
   localparam int NUM_COLS   = 7;                      // Words per line of the data file
   localparam int MAX_OPS    = 64;
   localparam int TIMEOUT    = 20;                     // Cycles allowed per wait loop

   localparam logic [31:0] OP_END    = 32'd0;
   localparam logic [31:0] OP_FILL   = 32'd1;
   localparam logic [31:0] OP_FETCH  = 32'd2;
   localparam logic [31:0] OP_DBG_WR = 32'd3;
   localparam logic [31:0] OP_DBG_RD = 32'd4;

   typedef logic [32-TAG_HIGH:0] tag_word_t;

   logic         clk;
   logic         arst_n;
   ic_addr_t     ic_rw_addr;
   logic         ic_rd_en;
   ic_way_vec_t  ic_wr_en;
   ic_data_t     ic_wr_data;
   ic_way_vec_t  ic_tag_valid;
   ic_dbg_addr_t ic_debug_addr;
   logic         ic_debug_rd_en;
   logic         ic_debug_wr_en;
   ic_way_vec_t  ic_debug_way;
   tag_word_t    ic_debug_wr_data;
   ic_way_vec_t  ic_rd_hit;
   ic_data_t     ic_rd_data;
   logic         ic_tag_perr;
   tag_word_t    ictag_debug_rd_data;

   logic [31:0] testdata [0:NUM_COLS*MAX_OPS-1];
   ic_data_t    model_data [NUM_WAYS][DATA_DEPTH];     // Filled chunks per way
   logic [31:0] lcg_state;

   // Request waiting for its response cycle
   logic [31:0] pend_op;
   logic [31:0] pend_addr;
   ic_way_vec_t pend_valid;
   logic [31:0] pend_exp_a;
   logic [31:0] pend_exp_b;

   int hit_errors;
   int data_errors;
   int perr_errors;
   int tag_errors;
   int timeouts;
   int wait_cnt;

   ic_mem #(
      .ICACHE_TAG_HIGH (TAG_HIGH)
   ) DUT (
      .clk                 (clk),
      .arst_n              (arst_n),
      .ic_rw_addr          (ic_rw_addr),
      .ic_rd_en            (ic_rd_en),
      .ic_wr_en            (ic_wr_en),
      .ic_wr_data          (ic_wr_data),
      .ic_tag_valid        (ic_tag_valid),
      .ic_debug_addr       (ic_debug_addr),
      .ic_debug_rd_en      (ic_debug_rd_en),
      .ic_debug_wr_en      (ic_debug_wr_en),
      .ic_debug_way        (ic_debug_way),
      .ic_debug_wr_data    (ic_debug_wr_data),
      .ic_rd_hit           (ic_rd_hit),
      .ic_rd_data          (ic_rd_data),
      .ic_tag_perr         (ic_tag_perr),
      .ictag_debug_rd_data (ictag_debug_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Payload generation and compares
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic ic_data_t make_payload();
      logic [31:0] w0;
      logic [31:0] w1;
      logic [31:0] w2;
      w0 = lcg_next();
      w1 = lcg_next();
      w2 = lcg_next();
      return {w2[3:0], w1, w0};
   endfunction

   task automatic check_way_vec(input ic_way_vec_t act, input ic_way_vec_t exp,
                                input string what);
      if (act !== exp) begin
         hit_errors++;
         $display("error at %0t: %s is %b, expected %b", $time, what, act, exp);
      end
   endtask

   task automatic check_data(input ic_data_t act, input ic_data_t exp, input string what);
      if (act !== exp) begin
         data_errors++;
         $display("error at %0t: %s is %h, expected %h", $time, what, act, exp);
      end
   endtask

   task automatic check_bit(input logic act, input logic exp, input string what);
      if (act !== exp) begin
         perr_errors++;
         $display("error at %0t: %s is %b, expected %b", $time, what, act, exp);
      end
   endtask

   task automatic check_tag(input tag_word_t act, input tag_word_t exp, input string what);
      if (act !== exp) begin
         tag_errors++;
         $display("error at %0t: %s is %h, expected %h", $time, what, act, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // One request per cycle
   ////////////////////////////////////////////////////////////////////////////

   task automatic drive_op(input logic [31:0] op, input logic [31:0] addr,
                           input logic [31:0] way, input logic [31:0] wdata);
      ic_data_t payload;
      ic_rd_en       = 1'b0;
      ic_wr_en       = '0;
      ic_debug_rd_en = 1'b0;
      ic_debug_wr_en = 1'b0;
      ic_debug_way   = '0;
      case (op)
         OP_FILL: begin
            payload    = make_payload();
            ic_rw_addr = addr[31:2];
            ic_wr_en   = way[NUM_WAYS-1:0];
            ic_wr_data = payload;
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (way[w]) model_data[w][addr[TAG_HIGH-1:3]] = payload;
            end
         end
         OP_FETCH: begin
            ic_rw_addr = addr[31:2];
            ic_rd_en   = 1'b1;
         end
         OP_DBG_WR: begin
            ic_debug_addr    = addr[15:2];
            ic_debug_way     = way[NUM_WAYS-1:0];
            ic_debug_wr_data = wdata[32-TAG_HIGH:0];    // Parity bit taken as given
            ic_debug_wr_en   = 1'b1;
         end
         OP_DBG_RD: begin
            ic_debug_addr  = addr[15:2];
            ic_debug_way   = way[NUM_WAYS-1:0];
            ic_debug_rd_en = 1'b1;
         end
         default: ;
      endcase
   endtask

   task automatic check_response();
      ic_data_t exp_data;
      exp_data = '0;
      case (pend_op)
         OP_FETCH: begin
            // Hitting ways return their filled chunk, a miss returns zero
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (pend_exp_a[w]) exp_data = exp_data | model_data[w][pend_addr[TAG_HIGH-1:3]];
            end
            check_way_vec(ic_rd_hit, pend_exp_a[NUM_WAYS-1:0], "ic_rd_hit");
            check_data(ic_rd_data, exp_data, "ic_rd_data");
            check_bit(ic_tag_perr, pend_exp_b[0], "ic_tag_perr");
         end
         OP_DBG_RD: check_tag(ictag_debug_rd_data, pend_exp_a[32-TAG_HIGH:0],
                              "ictag_debug_rd_data");
         default: ;
      endcase
   endtask

   task automatic run_cycle(input logic [31:0] op, input logic [31:0] addr,
                            input logic [31:0] way, input logic [31:0] wdata,
                            input logic [31:0] valid, input logic [31:0] exp_a,
                            input logic [31:0] exp_b);
      @(negedge clk);
      ic_tag_valid = pend_valid;                         // Previous request's response cycle
      drive_op(op, addr, way, wdata);
      #2;
      check_response();
      pend_op    = op;
      pend_addr  = addr;
      pend_valid = valid[NUM_WAYS-1:0];
      pend_exp_a = exp_a;
      pend_exp_b = exp_b;
   endtask

   initial begin
      int base;
      arst_n           = 1'b0;
      ic_rw_addr       = '0;
      ic_rd_en         = 1'b0;
      ic_wr_en         = '0;
      ic_wr_data       = '0;
      ic_tag_valid     = '0;
      ic_debug_addr    = '0;
      ic_debug_rd_en   = 1'b0;
      ic_debug_wr_en   = 1'b0;
      ic_debug_way     = '0;
      ic_debug_wr_data = '0;
      lcg_state        = 32'h63f7538d;
      pend_op          = OP_END;
      pend_addr        = '0;
      pend_valid       = '0;
      pend_exp_a       = '0;
      pend_exp_b       = '0;
      hit_errors       = 0;
      data_errors      = 0;
      perr_errors      = 0;
      tag_errors       = 0;
      timeouts         = 0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         for (int i = 0; i < DATA_DEPTH; i++) model_data[w][i] = '0;
      end
      $readmemh("ic_testdata.txt", testdata);

      repeat (2) @(negedge clk);
      arst_n = 1'b1;

      // Registered compare and debug state must come up cleared
      wait_cnt = 0;
      while (timeouts == 0 && (ic_rd_hit !== '0 || ictag_debug_rd_data !== '0)) begin
         if (wait_cnt == TIMEOUT) begin
            $display("timeout: DUT outputs did not clear after reset release");
            timeouts++;
         end else begin
            @(negedge clk);
            wait_cnt++;
         end
      end

      if (timeouts == 0) begin
         for (int i = 0; i < MAX_OPS; i++) begin
            base = i * NUM_COLS;
            if (testdata[base] == OP_END || $isunknown(testdata[base])) break;
            run_cycle(testdata[base], testdata[base+1], testdata[base+2], testdata[base+3],
                      testdata[base+4], testdata[base+5], testdata[base+6]);
         end

         // Drain the last response
         wait_cnt = 0;
         while (pend_op != OP_END && timeouts == 0) begin
            if (wait_cnt == TIMEOUT) begin
               $display("timeout: last response was never checked");
               timeouts++;
            end else begin
               run_cycle(OP_END, '0, '0, '0, '0, '0, '0);
               wait_cnt++;
            end
         end
      end

      $display("errors: hit %0d, data %0d, perr %0d, tag %0d, timeouts %0d",
               hit_errors, data_errors, perr_errors, tag_errors, timeouts);
      if (hit_errors + data_errors + perr_errors + tag_errors + timeouts == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
